// ==== Makefile ====
# Verilator flow for the analog data path
# make lint | make sim | make clean

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_rp_analog
LINT_TOP  ?= rp_analog_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
# extra options for the simulation build
VFLAGS    ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_clk_gen.sv ====
// clock and reset source for the testbench
// 4 ns adc_clk, top_rst held high over the first two rising edges

`timescale 1ns/10ps

module tb_clk_gen (
  output logic adc_clk_o,
  output logic top_rst_o
);

  // half period of 2 ns
  initial begin
    adc_clk_o = 1'b0;
    forever #2 adc_clk_o = ~adc_clk_o;
  end

  // release just after the second rising edge
  initial begin
    top_rst_o = 1'b1;
    repeat (2) @(posedge adc_clk_o);
    top_rst_o <= 1'b0;
  end

endmodule

// ==== bench/tb_rp_analog.sv ====
// testbench for the analog data path top level
// random ADC words and generator samples are driven on the falling edge,
// expected outputs wait in queues with their due cycle and are compared
// on the rising edge, then the expansion pin trigger is exercised

`timescale 1ns/10ps

module tb_rp_analog;

  // pipeline depth plus one, outputs are read before the edge updates them
  localparam int unsigned OSC_DUE  = 3 + 1;
  localparam int unsigned LOOP_DUE = 4 + 1;
  localparam int unsigned DAC_DUE  = 3 + 1;
  // quasi-static inputs need this long
  localparam int unsigned SETTLE   = 6;
  localparam int unsigned N_SMP    = 64;
  localparam int unsigned DRAIN_TO = 20;
  localparam int unsigned TRG_TO   = 4 * rp_pkg::DEB_LEN;
  localparam rp_pkg::cal_cfg_t UNITY = '{gain: 16'sh4000, offset: 14'sh0};

  // both channels of one cycle, due on a given rising edge
  typedef struct packed {
    int unsigned                               due;
    logic [rp_pkg::MNA-1:0][rp_pkg::SMP_W-1:0] val;
  } expect_t;

  logic                                adc_clk;
  logic                                top_rst;
  rp_pkg::adc_word_t [rp_pkg::MNA-1:0] adc_dat;
  rp_pkg::smp_t      [rp_pkg::MNG-1:0] gen_dat;
  rp_pkg::cal_cfg_t  [rp_pkg::MNA-1:0] adc_cal;
  rp_pkg::cal_cfg_t  [rp_pkg::MNG-1:0] dac_cal;
  logic                                digital_loop;
  logic                                exp_pin;
  rp_pkg::smp_t      [rp_pkg::MNA-1:0] osc_dat;
  rp_pkg::dac_code_t [rp_pkg::MNG-1:0] dac_dat;
  rp_pkg::trg_t                        trg;

  expect_t     osc_q[$];
  expect_t     dac_q[$];
  logic [31:0] lcg_state = 32'd15;
  int unsigned cyc = 0;
  int unsigned chk_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned pos_cnt = 0;
  int unsigned neg_cnt = 0;
  int unsigned chk_mark;
  int unsigned err_mark;
  int unsigned p0;
  int unsigned n0;
  string       test_name;

  tb_clk_gen i_clk (.adc_clk_o(adc_clk), .top_rst_o(top_rst));

  rp_analog_top i_dut (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .gen_dat_i      (gen_dat),
    .adc_cal_i      (adc_cal),
    .dac_cal_i      (dac_cal),
    .digital_loop_i (digital_loop),
    .exp_i          (exp_pin),
    .osc_dat_o      (osc_dat),
    .dac_dat_o      (dac_dat),
    .trg_o          (trg)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // sign bit kept, magnitude bits flipped, reserved lsbs dropped
  function automatic rp_pkg::smp_t adc_format(rp_pkg::adc_word_t w);
    rp_pkg::smp_t s;
    s[13]   = w[15];
    s[12:0] = ~w[14:2];
    return s;
  endfunction

  function automatic rp_pkg::smp_t cal_ref(rp_pkg::smp_t x, rp_pkg::cal_cfg_t cfg);
    rp_pkg::clm_t g;
    rp_pkg::smp_t s;
    longint       v;
    g = cfg.gain;
    s = cfg.offset;
    // floor of x*g / 2**14, then offset
    v = (longint'(x) * longint'(g)) >>> 14;
    v = v + longint'(s);
    if (v > 8191) v = 8191;
    if (v < -8192) v = -8192;
    return rp_pkg::smp_t'(v);
  endfunction

  // zero maps to mid-scale, full positive to code 0
  function automatic rp_pkg::dac_code_t dac_code_ref(rp_pkg::smp_t s);
    int c;
    c = 8191 - int'(s);
    return rp_pkg::dac_code_t'(c);
  endfunction

  // 1 and 2 push hard into saturation, 3 stays near unity
  function automatic rp_pkg::cal_cfg_t pick_cal(int round);
    rp_pkg::cal_cfg_t c;
    logic [31:0]      r;
    r = lcg_next();
    case (round)
      1: c = '{gain: 16'sh7fff, offset: 14'sd4000};
      2: c = '{gain: 16'sh8000, offset: -14'sd4000};
      3: c = '{gain: rp_pkg::clm_t'(8192 + int'(r[31:18])),
               offset: rp_pkg::smp_t'(int'(r[15:8]) - 128)};
      default: c = '{gain: r[31:16], offset: r[13:0]};
    endcase
    return c;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string what, logic [13:0] exp_v, logic [13:0] act_v);
    chk_cnt++;
    assert (exp_v == act_v) else begin
      err_cnt++;
      $display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  always @(posedge adc_clk) begin : compare
    expect_t e;
    cyc++;
    // trigger pulses counted for the debounce tests
    if (trg.gio_pos) pos_cnt++;
    if (trg.gio_neg) neg_cnt++;
    if (osc_q.size() != 0 && osc_q[0].due == cyc) begin
      e = osc_q.pop_front();
      for (int i = 0; i < rp_pkg::MNA; i++) begin
        check_value($sformatf("osc_dat_o[%0d]", i), e.val[i], osc_dat[i]);
      end
    end
    if (dac_q.size() != 0 && dac_q[0].due == cyc) begin
      e = dac_q.pop_front();
      for (int i = 0; i < rp_pkg::MNG; i++) begin
        check_value($sformatf("dac_dat_o[%0d]", i), e.val[i], dac_dat[i]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_reset_release();
    int unsigned t;
    t = 0;
    do begin
      @(negedge adc_clk);
      t++;
    end while (top_rst && t < 20);
    if (top_rst) begin
      err_cnt++;
      $display("timeout: reset was never released");
    end
  endtask

  // settle, stream, then wait until every expected sample was seen
  task automatic run_block(int unsigned n);
    expect_t      eo;
    expect_t      ed;
    rp_pkg::smp_t dc;
    logic [31:0]  r;
    int unsigned  t;
    repeat (SETTLE) @(negedge adc_clk);
    for (int k = 0; k < n; k++) begin
      @(negedge adc_clk);
      for (int i = 0; i < rp_pkg::MNA; i++) begin
        r = lcg_next();
        adc_dat[i] = r[31:16];
        r = lcg_next();
        gen_dat[i] = r[31:18];
        dc = cal_ref(gen_dat[i], dac_cal[i]);
        ed.val[i] = dac_code_ref(dc);
        // loopback replaces the ADC sample by the calibrated DAC sample
        eo.val[i] = digital_loop ? cal_ref(dc, adc_cal[i])
                                 : cal_ref(adc_format(adc_dat[i]), adc_cal[i]);
      end
      eo.due = cyc + (digital_loop ? LOOP_DUE : OSC_DUE);
      ed.due = cyc + DAC_DUE;
      osc_q.push_back(eo);
      dac_q.push_back(ed);
    end
    t = 0;
    while ((osc_q.size() != 0 || dac_q.size() != 0) && t < DRAIN_TO) begin
      @(negedge adc_clk);
      t++;
    end
    if (osc_q.size() != 0 || dac_q.size() != 0) begin
      err_cnt++;
      $display("timeout: %0d expected samples were never compared",
               osc_q.size() + dac_q.size());
      osc_q.delete();
      dac_q.delete();
    end
  endtask

  task automatic wait_pulse(bit rising);
    int unsigned base;
    int unsigned t;
    base = rising ? pos_cnt : neg_cnt;
    t = 0;
    while ((rising ? pos_cnt : neg_cnt) == base && t < TRG_TO) begin
      @(negedge adc_clk);
      t++;
    end
    if ((rising ? pos_cnt : neg_cnt) == base) begin
      err_cnt++;
      $display("timeout: no %s trigger pulse while the pin held its new level",
               rising ? "rising" : "falling");
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    chk_mark  = chk_cnt;
    err_mark  = err_cnt;
    p0        = pos_cnt;
    n0        = neg_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_mark) begin
      $display("test %s: ok, %0d checks", test_name, chk_cnt - chk_mark);
    end else begin
      $display("test %s: %0d errors in %0d checks", test_name,
               err_cnt - err_mark, chk_cnt - chk_mark);
    end
  endtask

  initial begin
    adc_dat      = '0;
    gen_dat      = '0;
    digital_loop = 1'b0;
    exp_pin      = 1'b0;
    for (int i = 0; i < rp_pkg::MNA; i++) begin
      adc_cal[i] = UNITY;
      dac_cal[i] = UNITY;
    end
    wait_reset_release();

    // nothing has moved through the pipes yet
    start_test("reset");
    for (int i = 0; i < rp_pkg::MNA; i++) begin
      check_value($sformatf("osc_dat_o[%0d]", i), 14'h0, osc_dat[i]);
      check_value($sformatf("dac_dat_o[%0d]", i), 14'h1fff, dac_dat[i]);
    end
    check_value("trg_o", 14'h0, {12'h0, trg});
    end_test();

    start_test("adc_unity");
    run_block(N_SMP);
    end_test();

    start_test("adc_cal");
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < rp_pkg::MNA; i++) adc_cal[i] = pick_cal(r);
      run_block(N_SMP);
    end
    end_test();

    start_test("dac_cal");
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < rp_pkg::MNG; i++) dac_cal[i] = pick_cal(r);
      run_block(N_SMP);
    end
    end_test();

    // ADC words keep changing and must not show up
    start_test("loopback");
    digital_loop = 1'b1;
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < rp_pkg::MNA; i++) begin
        adc_cal[i] = pick_cal(3);
        dac_cal[i] = pick_cal(r);
      end
      run_block(N_SMP);
    end
    digital_loop = 1'b0;
    end_test();

    // high for a few cycles less than the debounce length
    start_test("deb_glitch");
    exp_pin = 1'b1;
    repeat (rp_pkg::DEB_LEN - 4) @(negedge adc_clk);
    exp_pin = 1'b0;
    repeat (TRG_TO) @(negedge adc_clk);
    check_value("gio_pos pulses", 14'd0, 14'(pos_cnt - p0));
    check_value("gio_neg pulses", 14'd0, 14'(neg_cnt - n0));
    end_test();

    start_test("deb_rise");
    exp_pin = 1'b1;
    wait_pulse(1'b1);
    repeat (TRG_TO) @(negedge adc_clk);
    check_value("gio_pos pulses", 14'd1, 14'(pos_cnt - p0));
    check_value("gio_neg pulses", 14'd0, 14'(neg_cnt - n0));
    end_test();

    start_test("deb_fall");
    exp_pin = 1'b0;
    wait_pulse(1'b0);
    repeat (TRG_TO) @(negedge adc_clk);
    check_value("gio_pos pulses", 14'd0, 14'(pos_cnt - p0));
    check_value("gio_neg pulses", 14'd1, 14'(neg_cnt - n0));
    end_test();

    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // whole run takes a few microseconds
  initial begin
    #100000;
    $display("timeout: the run did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== src/adc_frontend.sv ====
// ADC side of the data path
// captures the pin words, converts to signed samples, picks ADC or
// loopback data and calibrates each channel into a scope sample
// three clocks from pin to scope, four from generator in loopback

`timescale 1ns/10ps

module adc_frontend (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // raw ADC pin words
  input  rp_pkg::adc_word_t [rp_pkg::MNA-1:0]   adc_dat_i,
  // calibrated DAC samples for loopback
  input  rp_pkg::smp_t      [rp_pkg::MNA-1:0]   dac_cal_i,
  // loopback select, quasi-static
  input  logic                                  digital_loop_i,
  // per channel calibration
  input  rp_pkg::cal_cfg_t  [rp_pkg::MNA-1:0]   cal_i,
  // scope samples
  output rp_pkg::smp_t      [rp_pkg::MNA-1:0]   osc_dat_o
);

  // captured and reformatted ADC samples
  rp_pkg::smp_t [rp_pkg::MNA-1:0] adc_raw_q;
  // calibration input after the loopback mux
  rp_pkg::smp_t [rp_pkg::MNA-1:0] cal_in;

  //////////////////////////////////////////////////////////////////////
  // per channel capture, mux and calibration
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < rp_pkg::MNA; i++) begin : g_adc

    // keep the msb, flip the magnitude bits, drop the two reserved lsbs
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        adc_raw_q[i] <= '0;
      end else begin
        adc_raw_q[i] <= {adc_dat_i[i][rp_pkg::ADC_W-1], ~adc_dat_i[i][rp_pkg::ADC_W-2:2]};
      end
    end

    // loopback mux, no register here
    assign cal_in[i] = digital_loop_i ? dac_cal_i[i] : adc_raw_q[i];

    linear_cal i_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .sti_i   (cal_in[i]),
      .cfg_i   (cal_i[i]),
      .sto_o   (osc_dat_o[i])
    );

  end

  // mux select must be a clean level once out of reset
  a_loop_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(digital_loop_i)
  );

endmodule

// ==== src/dac_backend.sv ====
// DAC side of the data path
// calibrates each generator stream and registers the DAC code
// calibrated samples also go back to the ADC side for loopback
// two clocks to dac_cal_o, three clocks to dac_dat_o

`timescale 1ns/10ps

module dac_backend (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // generator samples
  input  rp_pkg::smp_t      [rp_pkg::MNG-1:0]   gen_dat_i,
  // per channel calibration
  input  rp_pkg::cal_cfg_t  [rp_pkg::MNG-1:0]   cal_i,
  // calibrated samples, loopback source
  output rp_pkg::smp_t      [rp_pkg::MNG-1:0]   dac_cal_o,
  // registered DAC codes
  output rp_pkg::dac_code_t [rp_pkg::MNG-1:0]   dac_dat_o
);

  //////////////////////////////////////////////////////////////////////
  // per channel calibration and code conversion
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < rp_pkg::MNG; i++) begin : g_dac

    linear_cal i_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .sti_i   (gen_dat_i[i]),
      .cfg_i   (cal_i[i]),
      .sto_o   (dac_cal_o[i])
    );

    // signed to offset binary with negative slope
    // msb stays, the rest is inverted
    // a zero sample gives mid-scale 0x1fff, the reset value
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[i] <= {1'b0, {(rp_pkg::SMP_W-1){1'b1}}};
      end else begin
        dac_dat_o[i] <= {dac_cal_o[i][rp_pkg::SMP_W-1], ~dac_cal_o[i][rp_pkg::SMP_W-2:0]};
      end
    end

  end

endmodule

// ==== src/edge_debounce.sv ====
// debouncer for one expansion pin
// two flop synchronizer, then a level that only moves after the
// input held the other value for DEB_LEN cycles in a row
// each move gives a one cycle pulse on gio_pos or gio_neg

`timescale 1ns/10ps

module edge_debounce (
  input  logic         adc_clk,
  input  logic         top_rst,
  // asynchronous pin
  input  logic         d_i,
  // edge pulses
  output rp_pkg::trg_t trg_o
);

  // synchronizer, bit 1 is the safe one
  logic [1:0]       sync_q;
  // debounced level
  logic             lvl_q;
  // cycles the input has differed from lvl_q
  rp_pkg::deb_cnt_t cnt_q;

  //////////////////////////////////////////////////////////////////////
  // sync, count, flip
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
      lvl_q  <= 1'b0;
      cnt_q  <= '0;
      trg_o  <= '0;
    end else begin
      sync_q <= {sync_q[0], d_i};
      // pulses last one cycle only
      trg_o  <= '0;
      if (sync_q[1] == lvl_q) begin
        // glitch ended, start over
        cnt_q <= '0;
      end else if (cnt_q == rp_pkg::deb_cnt_t'(rp_pkg::DEB_LEN - 1)) begin
        // held long enough
        lvl_q         <= sync_q[1];
        cnt_q         <= '0;
        trg_o.gio_pos <= sync_q[1];
        trg_o.gio_neg <= ~sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // one edge at a time, the next one needs a fresh hold first
  a_trg_excl: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (trg_o.gio_pos || trg_o.gio_neg) |=> !(trg_o.gio_pos || trg_o.gio_neg)
  );

endmodule

// ==== src/linear_cal.sv ====
// one calibration channel, gain then offset with saturation
// two pipeline stages, one sample accepted every cycle
// output follows input by exactly two clocks

`timescale 1ns/10ps

module linear_cal (
  input  logic             adc_clk,
  input  logic             top_rst,
  // sample stream in
  input  rp_pkg::smp_t     sti_i,
  // gain and offset, quasi-static
  input  rp_pkg::cal_cfg_t cfg_i,
  // calibrated stream out
  output rp_pkg::smp_t     sto_o
);

  //////////////////////////////////////////////////////////////////////
  // stage one, full width product
  //////////////////////////////////////////////////////////////////////

  rp_pkg::prd_t prd_q;
  rp_pkg::prd_t sum;
  rp_pkg::smp_t sat;

  // both operands signed, so the casts sign extend
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd_q <= '0;
    end else begin
      prd_q <= rp_pkg::prd_t'(sti_i) * rp_pkg::prd_t'(cfg_i.gain);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage two, scale, offset, clamp
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // arithmetic shift keeps the sign
    sum = (prd_q >>> rp_pkg::CAL_SHIFT) + rp_pkg::prd_t'(cfg_i.offset);
    // in range when all bits above the sample msb match it
    if ((&sum[rp_pkg::PRD_W-1:rp_pkg::SMP_W-1]) ||
        (~|sum[rp_pkg::PRD_W-1:rp_pkg::SMP_W-1])) begin
      sat = sum[rp_pkg::SMP_W-1:0];
    end else begin
      // clamp to most positive or most negative
      sat = {sum[rp_pkg::PRD_W-1], {(rp_pkg::SMP_W-1){~sum[rp_pkg::PRD_W-1]}}};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sto_o <= '0;
    end else begin
      sto_o <= sat;
    end
  end

  // an unknown sample or config word upstream shows up here
  a_sat_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(sat)
  );

endmodule

// ==== src/rp_analog_top.sv ====
// analog data path top level, single adc_clk domain
// ADC capture and calibration, DAC calibration and codes,
// digital loopback and the expansion pin edge trigger
// calibration words and the loopback switch come in as levels

`timescale 1ns/10ps

module rp_analog_top (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // ADC pins
  input  rp_pkg::adc_word_t [rp_pkg::MNA-1:0]   adc_dat_i,
  // generator samples
  input  rp_pkg::smp_t      [rp_pkg::MNG-1:0]   gen_dat_i,
  // calibration
  input  rp_pkg::cal_cfg_t  [rp_pkg::MNA-1:0]   adc_cal_i,
  input  rp_pkg::cal_cfg_t  [rp_pkg::MNG-1:0]   dac_cal_i,
  // loopback switch
  input  logic                                  digital_loop_i,
  // expansion pin
  input  logic                                  exp_i,
  // scope samples
  output rp_pkg::smp_t      [rp_pkg::MNA-1:0]   osc_dat_o,
  // DAC codes, one register per channel
  output rp_pkg::dac_code_t [rp_pkg::MNG-1:0]   dac_dat_o,
  // edge triggers
  output rp_pkg::trg_t                          trg_o
);

  // calibrated generator samples, fed back for loopback
  rp_pkg::smp_t [rp_pkg::MNG-1:0] dac_cal;

  //////////////////////////////////////////////////////////////////////
  // data paths
  //////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat_i),
    .dac_cal_i      (dac_cal),
    .digital_loop_i (digital_loop_i),
    .cal_i          (adc_cal_i),
    .osc_dat_o      (osc_dat_o)
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .cal_i     (dac_cal_i),
    .dac_cal_o (dac_cal),
    .dac_dat_o (dac_dat_o)
  );

  // trigger from expansion pin
  edge_debounce i_deb (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .d_i     (exp_i),
    .trg_o   (trg_o)
  );

endmodule

// ==== src/rp_pkg.sv ====
// shared constants and types for the analog data path
// channel counts, sample and calibration widths, debounce length
// every design file refers to these by scoped names

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // channel counts
  //////////////////////////////////////////////////////////////////////

  // acquisition channels
  localparam int unsigned MNA = 2;
  // generator channels, must match MNA for loopback
  localparam int unsigned MNG = 2;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // signed sample
  localparam int unsigned SMP_W = 14;
  // ADC pin word, two lowest bits reserved
  localparam int unsigned ADC_W = 16;
  // calibration gain
  localparam int unsigned CLM_W = 16;
  // full width gain product
  localparam int unsigned PRD_W = SMP_W + CLM_W;
  // gain of 2**CAL_SHIFT is unity
  localparam int unsigned CAL_SHIFT = 14;

  // debounce length in cycles, kept short for simulation
  localparam int unsigned DEB_LEN = 16;
  localparam int unsigned DEB_CW = 5;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [SMP_W-1:0] smp_t;
  typedef logic        [ADC_W-1:0] adc_word_t;
  typedef logic        [SMP_W-1:0] dac_code_t;
  typedef logic signed [CLM_W-1:0] clm_t;
  typedef logic signed [PRD_W-1:0] prd_t;
  typedef logic       [DEB_CW-1:0] deb_cnt_t;

  // per channel calibration
  typedef struct packed {
    clm_t gain;
    smp_t offset;
  } cal_cfg_t;

  // expansion pin edge triggers
  typedef struct packed {
    logic gio_pos;
    logic gio_neg;
  } trg_t;

endpackage

// ==== tb.f ====
src/rp_pkg.sv
src/linear_cal.sv
src/adc_frontend.sv
src/dac_backend.sv
src/edge_debounce.sv
src/rp_analog_top.sv
bench/tb_clk_gen.sv
bench/tb_rp_analog.sv
